// File: verilog.f
+incdir+sim
source/pool_pkg.sv
source/layer_control.sv
source/atom_deserializer.sv
source/pool_lanes.sv
source/result_serializer.sv
source/pool_engine.sv
sim/pool_engine_tb.sv

// File: Makefile
VERILATOR  := verilator
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
TOP        := pool_engine_tb
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_TEXT)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/pool_tb_util.svh
`ifndef POOL_TB_UTIL_SVH
`define POOL_TB_UTIL_SVH

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

// Collects n fresh bits with one LFSR step per bit
function automatic logic [31:0] take_bits(input int n);
	logic [31:0] bits;
	bits = '0;
	for (int b = 0; b < n; b++) begin
		lfsr_state = lfsr_step(lfsr_state);
		bits       = {bits[30:0], lfsr_state[0]};
	end
	return bits;
endfunction

// Appends the expected write-back words of one layer to exp_q
// Word k of atom a sits at fed_q[a*BURST + k]
function automatic void predict_layer(input pool_op_e op, input int win_log2, input int windows);
	int n;
	int v;
	int best;
	int sum;
	int q;
	n = 1 << win_log2;
	for (int w = 0; w < windows; w++) begin
		for (int l = 0; l < BURST; l++) begin
			best = 0;
			sum  = 0;
			for (int a = 0; a < n; a++) begin
				v = int'(fed_q[(w * n + a) * BURST + l]);
				if (a == 0 || v > best) best = v;  // First atom seeds the max
				sum = sum + v;
			end
			if (op == OP_MAXPOOL) begin
				exp_q.push_back(word_t'(best));
			end else begin
				q = sum / n;                           // Truncates toward zero
				if ((sum % n != 0) && (sum < 0)) q--;  // Floor for negative sums
				exp_q.push_back(word_t'(q));
			end
		end
	end
endfunction

task automatic check_word(input string name, input word_t got, input word_t exp);
	if (got !== exp) begin
		$display("[FAIL] %s: got 0x%04h, expected 0x%04h", name, got, exp);
		word_errors++;
	end
endtask

task automatic check_state(input string name, input engine_state_e got, input engine_state_e exp);
	if (got !== exp) begin
		$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		state_errors++;
	end
endtask

task automatic check_level(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		level_errors++;
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp) begin
		$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		count_errors++;
	end
endtask

`endif

// File: sim/pool_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pool_engine_tb;
	import pool_pkg::*;

	localparam int BURST       = 4;     // Lanes per atom, kept small
	localparam int NUM_LAYERS  = 8;
	localparam int READY_LIMIT = 2000;  // Cycles allowed for the write-back tail
	localparam int FEED_SLACK  = 64;

	// One row of the stimulus table
	typedef struct packed {
		pool_op_e    op;
		logic [1:0]  window_log2;
		logic [15:0] windows;
		logic        gaps;  // Random idle cycles between strobes
	} layer_t;

	// Gap-free layers first, then paced layers back to back
	localparam layer_t LAYERS [NUM_LAYERS] = '{
		'{OP_MAXPOOL, 2'd2, 16'd3, 1'b0},  // Max over 4
		'{OP_AVEPOOL, 2'd3, 16'd3, 1'b0},  // Floor average over 8
		'{OP_MAXPOOL, 2'd0, 16'd5, 1'b0},  // Window 1 passes atoms through
		'{OP_AVEPOOL, 2'd0, 16'd5, 1'b0},
		'{OP_MAXPOOL, 2'd2, 16'd3, 1'b1},
		'{OP_AVEPOOL, 2'd3, 16'd2, 1'b1},
		'{OP_AVEPOOL, 2'd1, 16'd4, 1'b1},
		'{OP_MAXPOOL, 2'd1, 16'd2, 1'b1}
	};

	logic                      clk;
	logic                      rst;
	logic                      i_engine_valid;
	pool_op_e                  i_op;
	logic [WINDOW_LOG2_W-1:0]  i_window_log2;
	logic [WINDOWS_W-1:0]      i_windows;
	word_t                     i_dma_p2_ob_data;
	logic                      i_dma_p2_ob_we;
	logic                      o_dma_p2_reads_en;
	logic                      o_dma_p0_writes_en;
	word_t                     o_dma_p0_ib_data;
	logic                      o_engine_ready;
	engine_state_e             o_state;

	logic [31:0] lfsr_state;
	word_t       fed_q[$];      // Words of the current layer, in feed order
	word_t       exp_q[$];      // Expected writes of every layer so far
	int          exp_idx;       // Next expected write, owned by the monitor
	int          writes_total;  // All writes seen, owned by the monitor
	int          extra_writes;
	int          word_errors;
	int          state_errors;
	int          level_errors;
	int          count_errors;
	int          other_errors;
	logic        aborted;

	pool_engine #(.BURST_LEN(BURST)) pool_engine_i (
		.clk                (clk),
		.rst                (rst),
		.i_engine_valid     (i_engine_valid),
		.i_op               (i_op),
		.i_window_log2      (i_window_log2),
		.i_windows          (i_windows),
		.i_dma_p2_ob_data   (i_dma_p2_ob_data),
		.i_dma_p2_ob_we     (i_dma_p2_ob_we),
		.o_dma_p2_reads_en  (o_dma_p2_reads_en),
		.o_dma_p0_writes_en (o_dma_p0_writes_en),
		.o_dma_p0_ib_data   (o_dma_p0_ib_data),
		.o_engine_ready     (o_engine_ready),
		.o_state            (o_state)
	);

	`include "pool_tb_util.svh"

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Write port monitor, outputs settle well before the falling edge
	always @(negedge clk) begin
		if (!rst && o_dma_p0_writes_en) begin
			if (exp_idx >= exp_q.size()) begin
				$display("Write of 0x%04h seen while no word was expected", o_dma_p0_ib_data);
				extra_writes++;
			end else begin
				check_word("o_dma_p0_ib_data", o_dma_p0_ib_data, exp_q[exp_idx]);
				exp_idx++;
			end
			writes_total++;
		end
	end

	// Feeds one layer and checks its control levels and write count
	task automatic run_layer(input layer_t cfg);
		int total;
		int idx;
		int guard;
		int feed_limit;
		int wait_cnt;
		int start_writes;
		logic gap;
		total = (int'(cfg.windows) * BURST) << cfg.window_log2;
		fed_q.delete();
		for (idx = 0; idx < total; idx++) begin
			fed_q.push_back(word_t'(take_bits(WORD_W)));  // Random signed words
		end
		predict_layer(cfg.op, int'(cfg.window_log2), int'(cfg.windows));
		start_writes = writes_total;

		// Start strobe carries the layer settings
		i_engine_valid = 1'b1;
		i_op           = cfg.op;
		i_window_log2  = cfg.window_log2;
		i_windows      = cfg.windows;
		@(negedge clk);
		i_engine_valid = 1'b0;
		check_state("o_state", o_state, ST_IDLE);
		check_level("o_dma_p2_reads_en", o_dma_p2_reads_en, 1'b1);
		check_level("o_engine_ready", o_engine_ready, 1'b0);

		idx        = 0;
		guard      = 0;
		feed_limit = total * 40 + FEED_SLACK;
		while (idx < total && guard < feed_limit) begin
			gap = 1'b0;
			if (cfg.gaps) gap = (take_bits(1) != 0);  // One bit per cycle
			if (gap) begin
				i_dma_p2_ob_we = 1'b0;
			end else begin
				if (!o_dma_p2_reads_en) begin
					$display("Read enable was low when word %0d of %0d was due", idx, total);
					other_errors++;
				end
				i_dma_p2_ob_data = fed_q[idx];
				i_dma_p2_ob_we   = 1'b1;
				idx++;
			end
			@(negedge clk);
			guard++;
		end
		i_dma_p2_ob_we = 1'b0;
		if (idx < total) begin
			$display("Timed out feeding words, %0d of %0d sent", idx, total);
			other_errors++;
			aborted = 1'b1;
		end else begin
			// Atom valid now, read level drops at the next edge
			check_level("o_dma_p2_reads_en", o_dma_p2_reads_en, 1'b1);
			@(negedge clk);
			check_level("o_dma_p2_reads_en", o_dma_p2_reads_en, 1'b0);

			wait_cnt = 0;
			while (!o_engine_ready && wait_cnt < READY_LIMIT) begin
				@(negedge clk);
				wait_cnt++;
			end
			if (!o_engine_ready) begin
				$display("Timed out waiting for o_engine_ready");
				other_errors++;
				aborted = 1'b1;
			end else begin
				check_state("o_state", o_state, ST_FINISH);
				check_level("o_dma_p0_writes_en", o_dma_p0_writes_en, 1'b0);
				check_count("written words", writes_total - start_writes,
					int'(cfg.windows) * BURST);
			end
		end
	endtask

	initial begin
		rst              = 1'b1;
		i_engine_valid   = 1'b0;
		i_op             = OP_MAXPOOL;
		i_window_log2    = '0;
		i_windows        = '0;
		i_dma_p2_ob_data = '0;
		i_dma_p2_ob_we   = 1'b0;
		lfsr_state       = 32'h5c121957;
		exp_idx          = 0;
		writes_total     = 0;
		extra_writes     = 0;
		word_errors      = 0;
		state_errors     = 0;
		level_errors     = 0;
		count_errors     = 0;
		other_errors     = 0;
		aborted          = 1'b0;

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_level("o_engine_ready", o_engine_ready, 1'b0);
		check_level("o_dma_p2_reads_en", o_dma_p2_reads_en, 1'b0);
		check_level("o_dma_p0_writes_en", o_dma_p0_writes_en, 1'b0);
		check_state("o_state", o_state, ST_INIT);

		for (int i = 0; i < NUM_LAYERS && !aborted; i++) begin
			run_layer(LAYERS[i]);
		end
		repeat (4) @(negedge clk);  // Catch any stray write

		$display("Errors: %0d data, %0d state, %0d level, %0d count, %0d extra writes, %0d other",
			word_errors, state_errors, level_errors, count_errors, extra_writes, other_errors);
		if (word_errors + state_errors + level_errors + count_errors + extra_writes
			+ other_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: source/pool_engine.sv
`timescale 1ns/1ps
`default_nettype none

module pool_engine #(
	parameter int BURST_LEN = 16  // Channel lanes per atom
) (
	input  logic                                 clk,
	input  logic                                 rst,
	// Layer command
	input  logic                                 i_engine_valid,
	input  pool_pkg::pool_op_e                   i_op,
	input  logic [pool_pkg::WINDOW_LOG2_W-1:0]   i_window_log2,
	input  logic [pool_pkg::WINDOWS_W-1:0]       i_windows,
	// DMA read port
	input  pool_pkg::word_t                      i_dma_p2_ob_data,
	input  logic                                 i_dma_p2_ob_we,
	output logic                                 o_dma_p2_reads_en,
	// DMA write port
	output logic                                 o_dma_p0_writes_en,
	output pool_pkg::word_t                      o_dma_p0_ib_data,
	// Status
	output logic                                 o_engine_ready,
	output pool_pkg::engine_state_e              o_state
);
	import pool_pkg::*;

	layer_cfg_t            cfg_in;      // Command fields gathered for sampling
	layer_cfg_t            cfg;         // Sampled layer settings
	logic                  start;
	word_t [BURST_LEN-1:0] atom;
	logic                  atom_valid;
	word_t [BURST_LEN-1:0] result;
	logic                  result_valid;
	logic                  last_word;

	assign cfg_in = '{op: i_op, window_log2: i_window_log2, windows: i_windows};

	layer_control layer_control_i (
		.clk            (clk),
		.rst            (rst),
		.i_engine_valid (i_engine_valid),
		.i_cfg          (cfg_in),
		.i_atom_valid   (atom_valid),
		.i_last_word    (last_word),
		.o_cfg          (cfg),
		.o_start        (start),
		.o_reads_en     (o_dma_p2_reads_en),
		.o_engine_ready (o_engine_ready),
		.o_state        (o_state)
	);

	// Words to atoms
	atom_deserializer #(.BURST_LEN(BURST_LEN)) atom_deserializer_i (
		.clk          (clk),
		.rst          (rst),
		.i_start      (start),
		.i_data       (i_dma_p2_ob_data),
		.i_we         (i_dma_p2_ob_we),
		.o_atom       (atom),
		.o_atom_valid (atom_valid)
	);

	// Atoms to one result atom per window
	pool_lanes #(.BURST_LEN(BURST_LEN)) pool_lanes_i (
		.clk            (clk),
		.rst            (rst),
		.i_start        (start),
		.i_cfg          (cfg),
		.i_atom         (atom),
		.i_atom_valid   (atom_valid),
		.o_result       (result),
		.o_result_valid (result_valid)
	);

	// Result atom back to words
	result_serializer #(.BURST_LEN(BURST_LEN)) result_serializer_i (
		.clk            (clk),
		.rst            (rst),
		.i_result       (result),
		.i_result_valid (result_valid),
		.o_writes_en    (o_dma_p0_writes_en),
		.o_data         (o_dma_p0_ib_data),
		.o_last_word    (last_word)
	);

endmodule

`default_nettype wire

// File: source/result_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module result_serializer #(
	parameter int BURST_LEN = 16
) (
	input  logic                            clk,
	input  logic                            rst,
	input  pool_pkg::word_t [BURST_LEN-1:0] i_result,
	input  logic                            i_result_valid,
	output logic                            o_writes_en,   // One pulse per written word
	output pool_pkg::word_t                 o_data,
	output logic                            o_last_word
);
	import pool_pkg::*;

	localparam int LANE_W = $clog2(BURST_LEN);

	word_t [BURST_LEN-1:0] shift_q;  // Result atom, lane 0 at the bottom
	logic [LANE_W-1:0]     lane;     // Lane being written
	logic                  active;

	assign o_writes_en = active;
	assign o_data      = shift_q[0];
	assign o_last_word = active && (lane == LANE_W'(BURST_LEN - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active <= 1'b0;
			lane   <= '0;
		end else begin
			if (i_result_valid) begin
				active <= 1'b1;  // Writes start on the next cycle
				lane   <= '0;
			end else if (active) begin
				if (o_last_word) begin
					active <= 1'b0;
					lane   <= '0;
				end else begin
					lane <= lane + 1'b1;
				end
			end
		end
	end

	// Latch the atom, then move the next lane down every write
	always_ff @(posedge clk) begin
		if (i_result_valid) begin
			shift_q <= i_result;
		end else if (active) begin
			shift_q <= {WORD_W'(0), shift_q[BURST_LEN-1:1]};
		end
	end

endmodule

`default_nettype wire

// File: source/pool_lanes.sv
`timescale 1ns/1ps
`default_nettype none

module pool_lanes #(
	parameter int BURST_LEN = 16
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            i_start,
	input  pool_pkg::layer_cfg_t            i_cfg,
	input  pool_pkg::word_t [BURST_LEN-1:0] i_atom,
	input  logic                            i_atom_valid,
	output pool_pkg::word_t [BURST_LEN-1:0] o_result,
	output logic                            o_result_valid
);
	import pool_pkg::*;

	logic [MAX_WINDOW_LOG2-1:0] win_cnt;   // Atom index inside the current window
	logic [MAX_WINDOW_LOG2-1:0] win_end;   // Index of the last atom of a window
	logic                       win_first;
	logic                       win_last;

	word_t [BURST_LEN-1:0] max_q;  // Running maximum per lane
	word_t [BURST_LEN-1:0] max_d;
	acc_t  [BURST_LEN-1:0] sum_q;  // Running sum per lane
	acc_t  [BURST_LEN-1:0] sum_d;
	acc_t  [BURST_LEN-1:0] avg;    // Floor average of the finished window

	assign win_end   = MAX_WINDOW_LOG2'((1 << i_cfg.window_log2) - 1);
	assign win_first = (win_cnt == '0);
	assign win_last  = (win_cnt == win_end);

	// Next lane values, seeded by the first atom of a window
	always_comb begin
		for (int l = 0; l < BURST_LEN; l++) begin
			if (win_first || (i_atom[l] > max_q[l])) begin
				max_d[l] = i_atom[l];
			end else begin
				max_d[l] = max_q[l];
			end

			if (win_first) begin
				sum_d[l] = acc_t'(i_atom[l]);  // Sign extended
			end else begin
				sum_d[l] = sum_q[l] + acc_t'(i_atom[l]);
			end

			// Arithmetic shift rounds toward minus infinity
			avg[l] = sum_d[l] >>> i_cfg.window_log2;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			win_cnt        <= '0;
			o_result_valid <= 1'b0;
		end else begin
			o_result_valid <= i_atom_valid && win_last;  // One cycle after the window's last atom
			if (i_start) begin
				win_cnt <= '0;
			end else if (i_atom_valid) begin
				if (win_last) begin
					win_cnt <= '0;  // Windows never overlap
				end else begin
					win_cnt <= win_cnt + 1'b1;
				end
			end
		end
	end

	// Lane accumulators and result atom
	always_ff @(posedge clk) begin
		if (i_atom_valid) begin
			max_q <= max_d;
			sum_q <= sum_d;
			if (win_last) begin
				for (int l = 0; l < BURST_LEN; l++) begin
					if (i_cfg.op == OP_AVEPOOL) begin
						o_result[l] <= avg[l][WORD_W-1:0];  // Average always fits a word
					end else begin
						o_result[l] <= max_d[l];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/atom_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module atom_deserializer #(
	parameter int BURST_LEN = 16
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            i_start,       // Layer start, clears the burst count
	input  pool_pkg::word_t                 i_data,
	input  logic                            i_we,          // DMA data strobe
	output pool_pkg::word_t [BURST_LEN-1:0] o_atom,
	output logic                            o_atom_valid
);

	localparam int CNT_W = $clog2(BURST_LEN);

	logic [CNT_W-1:0] burst_cnt;
	logic [CNT_W-1:0] cnt_base;    // Count as seen this cycle, after a start clear
	logic             burst_done;

	// Start and a strobe may meet in the IDLE cycle
	assign cnt_base   = i_start ? '0 : burst_cnt;
	assign burst_done = i_we && (cnt_base == CNT_W'(BURST_LEN - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			burst_cnt    <= '0;
			o_atom_valid <= 1'b0;
		end else begin
			o_atom_valid <= burst_done;  // One cycle after the last word of the atom
			if (burst_done) begin
				burst_cnt <= '0;
			end else if (i_we) begin
				burst_cnt <= cnt_base + 1'b1;
			end else begin
				burst_cnt <= cnt_base;
			end
		end
	end

	// New word enters at the top lane and walks down
	// After BURST_LEN strobes the first word sits in lane 0
	always_ff @(posedge clk) begin
		if (i_we) begin
			o_atom <= {i_data, o_atom[BURST_LEN-1:1]};
		end
	end

endmodule

`default_nettype wire

// File: source/layer_control.sv
`timescale 1ns/1ps
`default_nettype none

module layer_control (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    i_engine_valid,  // Start strobe
	input  pool_pkg::layer_cfg_t    i_cfg,
	input  logic                    i_atom_valid,    // One atom deserialized
	input  logic                    i_last_word,     // Last word of a result atom written
	output pool_pkg::layer_cfg_t    o_cfg,
	output logic                    o_start,
	output logic                    o_reads_en,
	output logic                    o_engine_ready,
	output pool_pkg::engine_state_e o_state
);
	import pool_pkg::*;

	// Total atom count needs room for the window shift
	localparam int ATOM_W = WINDOWS_W + MAX_WINDOW_LOG2;

	engine_state_e          state;
	layer_cfg_t             cfg_q;
	logic [ATOM_W-1:0]      atom_cnt;    // Atoms received so far
	logic [ATOM_W-1:0]      atom_total;  // windows * 2**window_log2
	logic [WINDOWS_W-1:0]   win_cnt;     // Result atoms written so far
	logic                   reads_q;
	logic                   atoms_done;
	logic                   windows_done;

	assign atom_total = ATOM_W'(cfg_q.windows) << cfg_q.window_log2;

	// Last atom of the layer arriving now
	assign atoms_done   = i_atom_valid && (atom_cnt + 1'b1 == atom_total);
	assign windows_done = i_last_word && (win_cnt + 1'b1 == cfg_q.windows);

	assign o_cfg          = cfg_q;
	assign o_start        = (state == ST_IDLE);    // Single cycle, clears the pipeline counters
	assign o_reads_en     = reads_q;
	assign o_engine_ready = (state == ST_FINISH);  // Held until the next start
	assign o_state        = state;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= ST_INIT;
			cfg_q    <= '0;
			atom_cnt <= '0;
			win_cnt  <= '0;
			reads_q  <= 1'b0;
		end else begin
			case (state)
				ST_INIT, ST_FINISH: begin
					if (i_engine_valid) begin
						cfg_q    <= i_cfg;  // Layer settings fixed from here on
						atom_cnt <= '0;
						win_cnt  <= '0;
						reads_q  <= 1'b1;   // Read request goes up with the IDLE cycle
						state    <= ST_IDLE;
					end
				end
				ST_IDLE: begin
					state <= ST_BUSY;
				end
				ST_BUSY: begin
					// Input side, stop requesting once every atom is in
					if (i_atom_valid) begin
						atom_cnt <= atom_cnt + 1'b1;
					end
					if (atoms_done) begin
						reads_q <= 1'b0;
					end

					// Output side, layer ends with the final write-back
					if (i_last_word) begin
						win_cnt <= win_cnt + 1'b1;
					end
					if (windows_done) begin
						state <= ST_FINISH;
					end
				end
				default: begin
					state   <= ST_INIT;  // Unused codes fall back to INIT
					reads_q <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/pool_pkg.sv
`default_nettype none

package pool_pkg;

	// Data path widths
	localparam int WORD_W          = 16;
	localparam int MAX_WINDOW_LOG2 = 3;   // Windows of 1, 2, 4 or 8 atoms
	localparam int WINDOW_LOG2_W   = 2;
	localparam int WINDOWS_W       = 16;  // Result atoms per layer

	// One channel value as delivered by the DMA
	typedef logic signed [WORD_W-1:0] word_t;

	// Lane sum over the largest window, wide enough for 8 full-scale words
	typedef logic signed [WORD_W+MAX_WINDOW_LOG2-1:0] acc_t;

	// Opcodes, same encoding as the engine command word
	typedef enum logic [2:0] {
		OP_MAXPOOL = 3'd2,
		OP_AVEPOOL = 3'd3
	} pool_op_e;

	// Engine state as reported on o_state
	typedef enum logic [3:0] {
		ST_INIT   = 4'd0,
		ST_IDLE   = 4'd1,
		ST_BUSY   = 4'd2,
		ST_FINISH = 4'd3
	} engine_state_e;

	// Layer settings, sampled on the start strobe
	typedef struct packed {
		pool_op_e                 op;
		logic [WINDOW_LOG2_W-1:0] window_log2;  // Window size is 2**window_log2
		logic [WINDOWS_W-1:0]     windows;      // Number of result atoms
	} layer_cfg_t;

endpackage

`default_nettype wire
